// ==== hw/ifu_pkg.sv ====
// shared fetch types and constants; RV32I only, no compressed encodings, RESET_PC must be 8-byte aligned
package ifu_pkg;

    typedef logic [31:0] inst_addr_t;   // byte address of an instruction
    typedef logic [31:0] inst_t;        // one instruction word
    typedef logic [63:0] fetch_data_t;  // one AXI beat, two slots
    typedef logic [1:0]  axi_resp_t;    // RRESP encoding

    // beat layout
    // [31:0]  -> instruction at the 8-byte base
    // [63:32] -> instruction at base + 4

    localparam logic [6:0] OPC_JAL    = 7'b1101111;  // jal rd, imm
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;  // beq/bne/blt/bge/bltu/bgeu

    localparam inst_t INST_NOP = 32'h0000_0013;  // addi x0, x0, 0

    localparam axi_resp_t RESP_OKAY = 2'b00;  // anything else is an error

    // boot address, top parameter reset_pc overrides it
    localparam inst_addr_t RESET_PC = 32'h0000_0000;

endpackage

// ==== hw/ifu_pc_gen.sv ====
// fetch pc holds between accepts; a misaligned pc stalls fetch until the next redirect rewrites it
`timescale 1ns/1ps

module ifu_pc_gen #(
    parameter ifu_pkg::inst_addr_t reset_pc = ifu_pkg::RESET_PC
) (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                redirect_i,      // jump or predicted branch
    input  ifu_pkg::inst_addr_t target_i,        // redirect target
    input  logic                fetch_accept_i,  // AR handshake of a live read
    output ifu_pkg::inst_addr_t pc_o,
    output logic                pc_misaligned_o
);
    import ifu_pkg::*;

    inst_addr_t pc_q;        // current fetch address
    inst_addr_t pc_next_seq; // next 8-byte pair after pc_q

    // a half-pair entry at base+4 still steps to base+8
    assign pc_next_seq = {pc_q[31:3], 3'b000} + 32'd8;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q <= reset_pc;
        end else if (redirect_i) begin
            pc_q <= target_i;              // redirect beats sequential advance
        end else if (fetch_accept_i) begin
            pc_q <= pc_next_seq;           // pair requested, move on
        end
    end

    assign pc_o            = pc_q;
    assign pc_misaligned_o = |pc_q[1:0];   // level, clears only on redirect

endmodule

// ==== hw/ifu_axi_master.sv ====
// AXI read master with one single-beat read in flight; a read cancelled by redirect_i is drained and dropped
`timescale 1ns/1ps

module ifu_axi_master (
    input  logic                 clk,
    input  logic                 rst_i,
    input  ifu_pkg::inst_addr_t  pc_i,
    input  logic                 pc_misaligned_i,
    input  logic                 stall_i,
    input  logic                 redirect_i,
    output logic                 fetch_accept_o,   // pc_gen may advance
    output logic                 rsp_valid_o,      // live beat, okay response
    output ifu_pkg::fetch_data_t rsp_data_o,
    output ifu_pkg::inst_addr_t  rsp_addr_o,       // unaligned pc of the read
    output logic                 rsp_error_o,      // live beat, error response
    output ifu_pkg::inst_addr_t  m_axi_araddr_o,
    output logic                 m_axi_arvalid_o,
    input  logic                 m_axi_arready_i,
    input  ifu_pkg::fetch_data_t m_axi_rdata_i,
    input  ifu_pkg::axi_resp_t   m_axi_rresp_i,
    input  logic                 m_axi_rvalid_i,
    output logic                 m_axi_rready_o
);
    import ifu_pkg::*;

    typedef enum logic [1:0] {
        IDLE,   // nothing in flight
        ADDR,   // arvalid up, waiting arready
        DATA    // waiting for the R beat
    } state_t;

    state_t     state_q;
    logic       stale_q;    // read in flight was overtaken by a redirect
    inst_addr_t araddr_q;   // aligned address, stable while arvalid
    inst_addr_t req_pc_q;   // pc as requested

    logic start;            // launch a new read this cycle
    logic ar_hs;
    logic r_hs;
    logic r_live;           // beat belongs to the current pc stream

    assign start  = (state_q == IDLE) && !stall_i && !pc_misaligned_i && !redirect_i;
    assign ar_hs  = m_axi_arvalid_o && m_axi_arready_i;
    assign r_hs   = m_axi_rvalid_i && m_axi_rready_o;
    assign r_live = r_hs && !stale_q && !redirect_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= IDLE;
            stale_q <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    stale_q <= 1'b0;
                    if (start) begin
                        state_q <= ADDR;
                    end
                end
                ADDR: begin
                    if (ar_hs) begin
                        state_q <= DATA;
                    end
                    if (redirect_i) begin
                        stale_q <= 1'b1;   // address must still go out unchanged
                    end
                end
                DATA: begin
                    if (r_hs) begin
                        state_q <= IDLE;   // beat taken, live or dropped
                        stale_q <= 1'b0;
                    end else if (redirect_i) begin
                        stale_q <= 1'b1;
                    end
                end
                default: begin
                    state_q <= IDLE;
                    stale_q <= 1'b0;
                end
            endcase
        end
    end

    // request payload, captured at launch
    always_ff @(posedge clk) begin
        if (start) begin
            araddr_q <= {pc_i[31:3], 3'b000};
            req_pc_q <= pc_i;
        end
    end

    assign m_axi_araddr_o  = araddr_q;
    assign m_axi_arvalid_o = (state_q == ADDR);
    assign m_axi_rready_o  = (state_q == DATA) && !stall_i;  // back-pressure from decode

    // a cancelled read must not move the redirected pc
    assign fetch_accept_o = ar_hs && !stale_q && !redirect_i;

    assign rsp_valid_o = r_live && (m_axi_rresp_i == RESP_OKAY);
    assign rsp_error_o = r_live && (m_axi_rresp_i != RESP_OKAY);
    assign rsp_data_o  = m_axi_rdata_i;
    assign rsp_addr_o  = req_pc_q;

endmodule

// ==== hw/ifu_sbpu.sv ====
// static dual-slot predictor, combinational; jal always taken, branch taken on negative offset, no jalr
`timescale 1ns/1ps

module ifu_sbpu (
    input  logic                 rsp_valid_i,
    input  ifu_pkg::fetch_data_t rsp_data_i,
    input  ifu_pkg::inst_addr_t  rsp_addr_i,
    output logic                 branch_taken_o,
    output ifu_pkg::inst_addr_t  branch_addr_o,
    output logic                 pred1_o,        // slot 1 predicted taken
    output logic                 pred2_o,        // slot 2 predicted taken
    output logic                 slot2_kill_o    // slot 2 lies past a taken slot 1
);
    import ifu_pkg::*;

    // J-type immediate, sign extended
    function automatic inst_addr_t imm_j(input inst_t w);
        imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    endfunction

    // B-type immediate, sign extended
    function automatic inst_addr_t imm_b(input inst_t w);
        imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    endfunction

    // static rule, sign bit of a B immediate is inst[31]
    function automatic logic rule_taken(input inst_t w);
        logic is_jal;
        logic is_bwd_br;
        is_jal     = (w[6:0] == OPC_JAL);
        is_bwd_br  = (w[6:0] == OPC_BRANCH) && w[31];
        rule_taken = is_jal || is_bwd_br;
    endfunction

    inst_addr_t base;
    inst_addr_t addr1;
    inst_addr_t addr2;
    inst_t      word1;
    inst_t      word2;
    inst_addr_t off1;
    inst_addr_t off2;
    logic       slot1_ok;
    logic       slot2_ok;
    logic       take1;
    logic       take2;

    assign base  = {rsp_addr_i[31:3], 3'b000};
    assign addr1 = base;
    assign addr2 = base + 32'd4;
    assign word1 = rsp_data_i[31:0];
    assign word2 = rsp_data_i[63:32];

    assign slot1_ok = rsp_valid_i && !rsp_addr_i[2];  // half-pair entry skips slot 1
    assign slot2_ok = rsp_valid_i;

    assign off1 = (word1[6:0] == OPC_JAL) ? imm_j(word1) : imm_b(word1);
    assign off2 = (word2[6:0] == OPC_JAL) ? imm_j(word2) : imm_b(word2);

    assign take1 = slot1_ok && rule_taken(word1);
    assign take2 = slot2_ok && rule_taken(word2);

    // first taken slot wins
    assign pred1_o        = take1;
    assign pred2_o        = take2 && !take1;
    assign slot2_kill_o   = take1;
    assign branch_taken_o = take1 || take2;
    assign branch_addr_o  = take1 ? (addr1 + off1) : (addr2 + off2);

endmodule

// ==== hw/ifu_pipe.sv ====
// IF/ID register; valids pulse one cycle per fetched pair, stall holds everything, flush wins over load
`timescale 1ns/1ps

module ifu_pipe (
    input  logic                 clk,
    input  logic                 rst_i,
    input  logic                 stall_i,
    input  logic                 flush_i,
    input  logic                 rsp_valid_i,
    input  ifu_pkg::fetch_data_t rsp_data_i,
    input  ifu_pkg::inst_addr_t  rsp_addr_i,
    input  logic                 rsp_error_i,
    input  logic                 pred1_i,
    input  logic                 pred2_i,
    input  logic                 slot2_kill_i,
    output ifu_pkg::inst_t       inst1_o,
    output ifu_pkg::inst_addr_t  inst1_addr_o,
    output logic                 inst1_valid_o,
    output ifu_pkg::inst_t       inst2_o,
    output ifu_pkg::inst_addr_t  inst2_addr_o,
    output logic                 inst2_valid_o,
    output logic                 is_pred_branch1_o,
    output logic                 is_pred_branch2_o,
    output logic                 inst_valid_o,
    output logic                 read_resp_error_o
);
    import ifu_pkg::*;

    inst_addr_t base;
    logic       slot1_ok;   // fetched at an even word
    logic       slot2_ok;   // not shadowed by a taken slot 1
    logic       load;

    assign base     = {rsp_addr_i[31:3], 3'b000};
    assign slot1_ok = rsp_valid_i && !rsp_addr_i[2];
    assign slot2_ok = rsp_valid_i && !slot2_kill_i;
    assign load     = !stall_i && !flush_i && (rsp_valid_i || rsp_error_i);

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            inst1_valid_o     <= 1'b0;
            inst2_valid_o     <= 1'b0;
            is_pred_branch1_o <= 1'b0;
            is_pred_branch2_o <= 1'b0;
            read_resp_error_o <= 1'b0;
        end else if (!stall_i) begin
            inst1_valid_o     <= slot1_ok;
            inst2_valid_o     <= slot2_ok;
            is_pred_branch1_o <= rsp_valid_i && pred1_i;
            is_pred_branch2_o <= rsp_valid_i && pred2_i;
            read_resp_error_o <= rsp_error_i;  // error beat leaves both slots invalid
        end
    end

    // payload, nop in any slot that is not valid
    always_ff @(posedge clk) begin
        if (load) begin
            inst1_o      <= slot1_ok ? rsp_data_i[31:0] : INST_NOP;
            inst2_o      <= slot2_ok ? rsp_data_i[63:32] : INST_NOP;
            inst1_addr_o <= base;
            inst2_addr_o <= base + 32'd4;
        end
    end

    assign inst_valid_o = inst1_valid_o || inst2_valid_o;

endmodule

// ==== hw/ifu.sv ====
// fetch unit top; external jump has priority over the predicted target, stall_i and flush_i are levels
`timescale 1ns/1ps

module ifu #(
    parameter ifu_pkg::inst_addr_t reset_pc = ifu_pkg::RESET_PC
) (
    input  logic                 clk,
    input  logic                 rst_i,
    input  logic                 jump_i,             // one-cycle pulse
    input  ifu_pkg::inst_addr_t  jump_addr_i,
    input  logic                 stall_i,
    input  logic                 flush_i,
    output ifu_pkg::inst_t       inst1_o,
    output ifu_pkg::inst_addr_t  inst1_addr_o,
    output logic                 inst1_valid_o,
    output ifu_pkg::inst_t       inst2_o,
    output ifu_pkg::inst_addr_t  inst2_addr_o,
    output logic                 inst2_valid_o,
    output logic                 is_pred_branch1_o,
    output logic                 is_pred_branch2_o,
    output logic                 inst_valid_o,
    output logic                 read_resp_error_o,
    output logic                 pc_misaligned_o,
    output ifu_pkg::inst_addr_t  m_axi_araddr_o,
    output logic                 m_axi_arvalid_o,
    input  logic                 m_axi_arready_i,
    input  ifu_pkg::fetch_data_t m_axi_rdata_i,
    input  ifu_pkg::axi_resp_t   m_axi_rresp_i,
    input  logic                 m_axi_rvalid_i,
    output logic                 m_axi_rready_o
);
    import ifu_pkg::*;

    inst_addr_t  pc;
    logic        pc_misaligned;
    logic        fetch_accept;
    logic        rsp_valid;
    fetch_data_t rsp_data;
    inst_addr_t  rsp_addr;
    logic        rsp_error;
    logic        branch_taken;
    inst_addr_t  branch_addr;
    logic        pred1;
    logic        pred2;
    logic        slot2_kill;
    logic        redirect;
    inst_addr_t  target;

    // jump merge
    assign redirect = jump_i || branch_taken;
    assign target   = jump_i ? jump_addr_i : branch_addr;

    ifu_pc_gen #(.reset_pc(reset_pc)) pc_gen_i (
        .clk(clk), .rst_i(rst_i), .redirect_i(redirect), .target_i(target),
        .fetch_accept_i(fetch_accept), .pc_o(pc), .pc_misaligned_o(pc_misaligned)
    );

    // master cancels on jump_i only, a predicted redirect comes from the live beat itself
    ifu_axi_master axi_master_i (
        .clk(clk), .rst_i(rst_i), .pc_i(pc), .pc_misaligned_i(pc_misaligned),
        .stall_i(stall_i), .redirect_i(jump_i), .fetch_accept_o(fetch_accept),
        .rsp_valid_o(rsp_valid), .rsp_data_o(rsp_data), .rsp_addr_o(rsp_addr),
        .rsp_error_o(rsp_error), .m_axi_araddr_o(m_axi_araddr_o),
        .m_axi_arvalid_o(m_axi_arvalid_o), .m_axi_arready_i(m_axi_arready_i),
        .m_axi_rdata_i(m_axi_rdata_i), .m_axi_rresp_i(m_axi_rresp_i),
        .m_axi_rvalid_i(m_axi_rvalid_i), .m_axi_rready_o(m_axi_rready_o)
    );

    ifu_sbpu sbpu_i (
        .rsp_valid_i(rsp_valid), .rsp_data_i(rsp_data), .rsp_addr_i(rsp_addr),
        .branch_taken_o(branch_taken), .branch_addr_o(branch_addr),
        .pred1_o(pred1), .pred2_o(pred2), .slot2_kill_o(slot2_kill)
    );

    ifu_pipe pipe_i (
        .clk(clk), .rst_i(rst_i), .stall_i(stall_i), .flush_i(flush_i),
        .rsp_valid_i(rsp_valid), .rsp_data_i(rsp_data), .rsp_addr_i(rsp_addr),
        .rsp_error_i(rsp_error), .pred1_i(pred1), .pred2_i(pred2),
        .slot2_kill_i(slot2_kill), .inst1_o(inst1_o), .inst1_addr_o(inst1_addr_o),
        .inst1_valid_o(inst1_valid_o), .inst2_o(inst2_o), .inst2_addr_o(inst2_addr_o),
        .inst2_valid_o(inst2_valid_o), .is_pred_branch1_o(is_pred_branch1_o),
        .is_pred_branch2_o(is_pred_branch2_o), .inst_valid_o(inst_valid_o),
        .read_resp_error_o(read_resp_error_o)
    );

    assign pc_misaligned_o = pc_misaligned;

endmodule

// ==== bench/tb_ifu.sv ====
// ifu testbench; memory answers in 0..3 cycles, sites at 0x100, 0x204, 0x400-0x4ff and 0x600 only
`timescale 1ns/1ps

module tb_ifu;
    import ifu_pkg::*;

    localparam inst_addr_t BOOT_PC  = 32'h0000_0000;
    localparam inst_addr_t SITE_BR  = 32'h0000_0100;  // beq x0, x0, backward
    localparam inst_addr_t SITE_JAL = 32'h0000_0204;  // jal x0, forward
    localparam inst_addr_t SITE_ERR = 32'h0000_0600;  // slave error
    localparam inst_addr_t BR_OFF   = 32'hFFFF_FFC0;  // -0x40
    localparam inst_addr_t JAL_OFF  = 32'h0000_0100;
    localparam int MAX_CYCLES = 4000;  // six tests of a few dozen pairs, ~5 cycles per pair

    logic        clk;
    logic        rst_i;
    logic        jump_i;
    inst_addr_t  jump_addr_i;
    logic        stall_i;
    logic        flush_i;
    inst_t       inst1_o;
    inst_addr_t  inst1_addr_o;
    logic        inst1_valid_o;
    inst_t       inst2_o;
    inst_addr_t  inst2_addr_o;
    logic        inst2_valid_o;
    logic        is_pred_branch1_o;
    logic        is_pred_branch2_o;
    logic        inst_valid_o;
    logic        read_resp_error_o;
    logic        pc_misaligned_o;
    inst_addr_t  m_axi_araddr_o;
    logic        m_axi_arvalid_o;
    logic        m_axi_arready_i;
    fetch_data_t m_axi_rdata_i;
    axi_resp_t   m_axi_rresp_i;
    logic        m_axi_rvalid_i;
    logic        m_axi_rready_o;

    logic [31:0]  rnd;
    logic         pending;        // read accepted, beat not yet shown
    logic [1:0]   delay;
    inst_addr_t   req_addr;
    logic         ar_hs_seen;     // handshakes sampled at the falling edge
    logic         r_hs_seen;
    inst_addr_t   ar_addr_seen;
    inst_addr_t   expect_pc;      // reference fetch address
    inst_addr_t   last_base;
    logic [132:0] held;           // outputs at the previous falling edge
    logic [132:0] pipe_now;
    logic         stall_d;
    logic         flush_d;
    logic         mis_d;
    logic         arv_d;
    logic         seen_half;
    logic         seen_pred1;
    logic         seen_pred2;
    logic         seen_error;
    logic         mis_ok;
    logic         beat_held;      // R beat waiting behind the stall
    int pairs = 0;
    int errors = 0;
    int tests_ok = 0;
    int tests_bad = 0;
    int stall_checks = 0;
    int flush_checks = 0;
    int cycles = 0;
    int err0;
    int sc0;
    int fc0;

    ifu #(.reset_pc(BOOT_PC)) ifu_i (.*);

    assign pipe_now = {inst1_o, inst1_addr_o, inst1_valid_o, inst2_o, inst2_addr_o,
                       inst2_valid_o, is_pred_branch1_o, is_pred_branch2_o, read_resp_error_o};

    always #20 clk = ~clk;

    // RV32 encoders, rs1 = rs2 = rd = x0
    function automatic inst_t enc_beq(input inst_addr_t off);
        enc_beq = {off[12], off[10:5], 5'd0, 5'd0, 3'b000, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic inst_t enc_jal(input inst_addr_t off);
        enc_jal = {off[20], off[10:1], off[11], off[19:12], 5'd0, OPC_JAL};
    endfunction

    function automatic inst_t mem_word(input inst_addr_t a);
        if (a == SITE_BR) begin
            mem_word = enc_beq(BR_OFF);
        end else if (a == SITE_JAL) begin
            mem_word = enc_jal(JAL_OFF);
        end else if (a >= 32'h400 && a <= 32'h4FF) begin
            mem_word = a;                      // address as data
        end else begin
            mem_word = INST_NOP;
        end
    endfunction

    // jal always, branch only backward
    function automatic logic site_taken(input inst_addr_t a);
        site_taken = (a == SITE_JAL) || ((a == SITE_BR) && BR_OFF[31]);
    endfunction

    function automatic inst_addr_t site_target(input inst_addr_t a);
        site_target = (a == SITE_JAL) ? a + JAL_OFF : a + BR_OFF;
    endfunction

    task automatic flag_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        $display("Error: %s is %h, expected %h", name, got, exp);
        errors++;
    endtask

    task automatic flag_bit(input string name, input logic got, input logic exp);
        $display("Error: %s is %h, expected %h", name, got, exp);
        errors++;
    endtask

    task automatic note_failure(input string msg);
        $display("%s", msg);
        errors++;
    endtask

    // one delivered pair against the reference pc, then advance it
    task automatic check_pair();
        inst_addr_t base;
        logic       s1;
        logic       p1;
        logic       p2;
        inst_t      w1;
        inst_t      w2;
        base = {expect_pc[31:3], 3'b000};
        s1   = !expect_pc[2];                  // half-pair entry drops slot 1
        p1   = s1 && site_taken(base);
        p2   = !p1 && site_taken(base + 32'd4);
        w1   = s1 ? mem_word(base) : INST_NOP;
        w2   = !p1 ? mem_word(base + 32'd4) : INST_NOP;
        assert (expect_pc[1:0] == 2'b00) else note_failure("a pair came from a misaligned pc");
        assert (inst1_addr_o == base) else flag_word("inst1_addr_o", inst1_addr_o, base);
        assert (inst2_addr_o == base + 32'd4)
            else flag_word("inst2_addr_o", inst2_addr_o, base + 32'd4);
        if (base == SITE_ERR) begin
            assert (read_resp_error_o) else flag_bit("read_resp_error_o", read_resp_error_o, 1'b1);
            assert (!inst1_valid_o) else flag_bit("inst1_valid_o", inst1_valid_o, 1'b0);
            assert (!inst2_valid_o) else flag_bit("inst2_valid_o", inst2_valid_o, 1'b0);
            seen_error = 1'b1;
            expect_pc  = base + 32'd8;
        end else begin
            assert (!read_resp_error_o) else flag_bit("read_resp_error_o", read_resp_error_o, 1'b0);
            assert (inst1_valid_o == s1) else flag_bit("inst1_valid_o", inst1_valid_o, s1);
            assert (inst2_valid_o == !p1) else flag_bit("inst2_valid_o", inst2_valid_o, !p1);
            assert (is_pred_branch1_o == p1)
                else flag_bit("is_pred_branch1_o", is_pred_branch1_o, p1);
            assert (is_pred_branch2_o == p2)
                else flag_bit("is_pred_branch2_o", is_pred_branch2_o, p2);
            assert (inst1_o == w1) else flag_word("inst1_o", inst1_o, w1);
            assert (inst2_o == w2) else flag_word("inst2_o", inst2_o, w2);
            seen_half  = seen_half || !s1;
            seen_pred1 = seen_pred1 || p1;
            seen_pred2 = seen_pred2 || p2;
            if (p1) begin
                expect_pc = site_target(base);
            end else if (p2) begin
                expect_pc = site_target(base + 32'd4);
            end else begin
                expect_pc = base + 32'd8;
            end
        end
        last_base = base;
        pairs++;
    endtask

    // all outputs stable here, inputs move 2 ns after the rising edge
    always @(negedge clk) begin
        if (rst_i) begin
            expect_pc = BOOT_PC;
            stall_d   = 1'b0;
            flush_d   = 1'b0;
        end else begin
            if (stall_d && !flush_d) begin
                stall_checks++;
                assert (pipe_now == held) else begin
                    $display("Error: pipe outputs %h under stall, held value %h", pipe_now, held);
                    errors++;
                end
            end
            if (flush_d) begin
                flush_checks++;
                assert (!inst_valid_o && !read_resp_error_o)
                    else note_failure("flush left a valid pair on the outputs");
            end
            assert (!(stall_i && m_axi_rready_o)) else note_failure("rready high during stall");
            assert (!(m_axi_arvalid_o && !arv_d && (mis_d || stall_d)))
                else note_failure("a read started while stalled or misaligned");
            if ((inst_valid_o || read_resp_error_o) && !stall_d) begin
                check_pair();
            end
            if (jump_i) begin
                expect_pc = jump_addr_i;       // after the old pair is checked
            end
            stall_d = stall_i;
            flush_d = flush_i;
        end
        held         = pipe_now;
        mis_d        = pc_misaligned_o;
        arv_d        = m_axi_arvalid_o;
        ar_hs_seen   = m_axi_arvalid_o && m_axi_arready_i;
        ar_addr_seen = m_axi_araddr_o;
        r_hs_seen    = m_axi_rvalid_i && m_axi_rready_o;
    end

    // AXI slave, single beat per read
    always begin
        @(posedge clk);
        #2;
        rnd = $urandom;
        if (r_hs_seen) begin
            m_axi_rvalid_i = 1'b0;
        end
        if (ar_hs_seen) begin
            pending  = 1'b1;
            req_addr = ar_addr_seen;
            delay    = rnd[5:4];               // 0..3 cycles to rvalid
        end
        if (pending && !m_axi_rvalid_i) begin
            if (delay == 2'd0) begin
                m_axi_rvalid_i = 1'b1;
                m_axi_rdata_i  = {mem_word(req_addr + 32'd4), mem_word(req_addr)};
                m_axi_rresp_i  = (req_addr == SITE_ERR) ? 2'b10 : RESP_OKAY;
                pending        = 1'b0;
            end else begin
                delay = delay - 2'd1;
            end
        end
        m_axi_arready_i = rnd[0];
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, the tests did not finish", cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic jump_to(input inst_addr_t a);
        jump_i      = 1'b1;
        jump_addr_i = a;
        step();
        jump_i      = 1'b0;
    endtask

    task automatic wait_pairs(input int n);
        int goal_cnt;
        goal_cnt = pairs + n;
        while (pairs < goal_cnt) begin
            step();
        end
    endtask

    task automatic close_test(input int num, input string name, input logic goal);
        if (!goal) begin
            note_failure($sformatf("test %0d did not reach the case it targets", num));
        end
        if (errors == err0) begin
            $display("test %0d %s: ok", num, name);
            tests_ok++;
        end else begin
            $display("test %0d %s: failed, %0d errors", num, name, errors - err0);
            tests_bad++;
        end
    endtask

    initial begin
        rnd             = $urandom(54);        // one seed for the run
        clk             = 1'b0;
        rst_i           = 1'b1;
        jump_i          = 1'b0;
        jump_addr_i     = '0;
        stall_i         = 1'b0;
        flush_i         = 1'b0;
        m_axi_arready_i = 1'b0;
        m_axi_rvalid_i  = 1'b0;
        m_axi_rdata_i   = '0;
        m_axi_rresp_i   = RESP_OKAY;
        pending         = 1'b0;
        delay           = 2'd0;
        req_addr        = '0;
        seen_half       = 1'b0;
        seen_pred1      = 1'b0;
        seen_pred2      = 1'b0;
        seen_error      = 1'b0;
        beat_held       = 1'b0;
        repeat (3) step();
        rst_i = 1'b0;
        wait_pairs(2);                         // boot stream

        err0 = errors;
        jump_to(32'h400);
        wait_pairs(6);
        close_test(1, "sequential fetch", last_base == 32'h428);

        err0 = errors;
        jump_to(32'h40C);
        wait_pairs(1);
        close_test(2, "half-pair entry", seen_half && last_base == 32'h408);

        err0 = errors;
        jump_to(SITE_BR);
        wait_pairs(2);                         // branch pair, then its target
        mis_ok = seen_pred1 && last_base == 32'h0C0;
        jump_to(32'h200);
        wait_pairs(2);
        close_test(3, "static prediction", mis_ok && seen_pred2 && last_base == 32'h300);

        err0 = errors;
        do step(); while (!ar_hs_seen);        // read now outstanding
        jump_to(32'h480);
        wait_pairs(2);
        close_test(4, "stale read dropped", last_base == 32'h488);

        err0 = errors;
        sc0  = stall_checks;
        fc0  = flush_checks;
        do step(); while (!inst_valid_o);
        stall_i = 1'b1;                        // valid pair held, master idle
        repeat (6) step();
        stall_i = 1'b0;
        do step(); while (!ar_hs_seen);
        stall_i = 1'b1;                        // read in flight, beat must wait
        repeat (6) step();
        beat_held = m_axi_rvalid_i && !m_axi_rready_o;
        stall_i   = 1'b0;
        flush_i   = 1'b1;                      // beat lands under the flush
        step();
        flush_i = 1'b0;
        jump_to(32'h440);
        wait_pairs(1);
        close_test(5, "stall and flush",
                   stall_checks - sc0 >= 5 && flush_checks > fc0 && beat_held &&
                   last_base == 32'h440);

        err0 = errors;
        jump_to(32'h402);
        repeat (20) step();                    // window for a forbidden read
        mis_ok = pc_misaligned_o;
        jump_to(SITE_ERR);
        wait_pairs(1);
        close_test(6, "faults", mis_ok && seen_error);

        $display("results: %0d tests ok, %0d tests failed, %0d check errors",
                 tests_ok, tests_bad, errors);
        if (tests_bad == 0 && errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
hw/ifu_pkg.sv
hw/ifu_pc_gen.sv
hw/ifu_axi_master.sv
hw/ifu_sbpu.sv
hw/ifu_pipe.sv
hw/ifu.sv
bench/tb_ifu.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_ifu -Mdir obj_dir -f tb.f
	out=$$(./obj_dir/Vtb_ifu); echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir
